// File: filelist.f
+incdir+include
hw/cpu_pkg.sv
hw/decode.sv
hw/hazard_unit.sv
hw/exec_unit.sv
hw/regfile.sv
hw/pipeline.sv
hw/cpu_top.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

// File: Makefile
# Verilator build and run of the CPU testbench
TOP := cpu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tests/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int HALT_TIMEOUT = 2000;
    localparam int STEP_LIMIT   = 1000;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] i_addr;
    logic [`XLEN-1:0] mem_rd_data;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wr_data;
    logic             mem_wr;
    logic             halted;

    logic [`XLEN-1:0] imem [MEM_WORDS];
    logic [`XLEN-1:0] dmem [MEM_WORDS];
    logic [`XLEN-1:0] dmem_init [MEM_WORDS];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];

    integer seed;
    int     prog_len;
    int     exp_count;
    int     store_count;
    int     value_errors;
    int     other_errors;
    int     wait_cycles;

    cpu_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .instr(instr), .i_addr(i_addr),
        .mem_rd_data(mem_rd_data), .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data), .mem_wr(mem_wr),
        .halted(halted)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////

    // Both ports read combinationally, word indexed
    assign instr       = imem[i_addr[9:2]];
    assign mem_rd_data = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_wr)
            dmem[mem_addr[9:2]] <= mem_wr_data;
    end

    function automatic logic [`XLEN-1:0] encode_r(input opcode_e op, input int rd,
                                                   input int rs1, input int rs2);
        encode_r = {op, rs1[4:0], rs2[4:0], rd[4:0], 11'h000};
    endfunction

    // rt sits in the rs2 field
    function automatic logic [`XLEN-1:0] encode_i(input opcode_e op, input int rt,
                                                   input int rs1, input int imm);
        encode_i = {op, rs1[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic emit_instr(input logic [`XLEN-1:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_program();
        int rnd_a;
        int rnd_b;
        int rnd_c;
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        rnd_c = $random(seed) | 1;
        // Opcode 0 is a no-op, low bits carry the word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]      = {6'h00, i[25:0]};
            dmem_init[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
        end
        dmem_init[2] = $random(seed);
        dmem_init[3] = $random(seed);
        // Dependent ALU chain, then stores of every result
        emit_instr(encode_i(OP_ADDI, 1, 0, 32'h200));
        emit_instr(encode_i(OP_ADDI, 2, 0, rnd_a));
        emit_instr(encode_i(OP_ADDI, 3, 0, rnd_b));
        emit_instr(encode_r(OP_ADD, 4, 2, 3));
        emit_instr(encode_r(OP_SUB, 5, 4, 2));
        emit_instr(encode_r(OP_AND, 6, 5, 4));
        emit_instr(encode_r(OP_OR, 7, 6, 3));
        emit_instr(encode_r(OP_SLT, 8, 7, 5));
        for (int r = 4; r <= 8; r++)
            emit_instr(encode_i(OP_SW, r, 1, (r - 4) * 4));
        // Load-use pairs
        emit_instr(encode_i(OP_LW, 9, 0, 8));
        emit_instr(encode_r(OP_ADD, 10, 9, 2));
        emit_instr(encode_i(OP_SW, 10, 1, 20));
        emit_instr(encode_i(OP_LW, 11, 0, 12));
        emit_instr(encode_r(OP_ADD, 12, 11, 11));
        emit_instr(encode_i(OP_SW, 12, 1, 24));
        emit_instr(encode_i(OP_LW, 13, 0, 16));
        emit_instr(encode_i(OP_SW, 13, 1, 28));
        // Each taken branch or jump skips three stores
        emit_instr(encode_i(OP_ADDI, 14, 0, 0));
        emit_instr(encode_i(OP_BEQZ, 0, 14, 3));
        for (int r = 2; r <= 4; r++)
            emit_instr(encode_i(OP_SW, r, 1, 32 + (r - 2) * 4));
        emit_instr(encode_i(OP_BNEZ, 0, 14, 3));
        emit_instr(encode_i(OP_SW, 2, 1, 44));
        emit_instr(encode_i(OP_ADDI, 15, 0, rnd_c));
        emit_instr(encode_i(OP_BNEZ, 0, 15, 3));
        for (int r = 3; r <= 5; r++)
            emit_instr(encode_i(OP_SW, r, 1, 48 + (r - 3) * 4));
        emit_instr(encode_i(OP_BEQZ, 0, 15, 3));
        emit_instr(encode_i(OP_SW, 6, 1, 60));
        emit_instr(encode_i(OP_J, 0, 0, 3));
        for (int r = 7; r <= 9; r++)
            emit_instr(encode_i(OP_SW, r, 1, 64 + (r - 7) * 4));
        emit_instr(encode_i(OP_SW, 15, 1, 76));
        emit_instr(encode_i(OP_HALT, 0, 0, 0));
        emit_instr(encode_i(OP_SW, 2, 1, 80));
        emit_instr(encode_i(OP_SW, 3, 1, 84));
    endtask

    //////////////////////////////////////////////////
    // Architectural model
    //////////////////////////////////////////////////

    // Runs the program one instruction at a time, fills the expected stores
    function automatic int run_reference();
        logic [`XLEN-1:0] regs [32];
        logic [`XLEN-1:0] dm [MEM_WORDS];
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] w;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] ea;
        logic             done;
        int               steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            dm[i] = dmem_init[i];
        pc    = `RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < STEP_LIMIT) begin
            w   = imem[pc[9:2]];
            a   = regs[w[25:21]];
            b   = regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            ea  = a + imm;
            pc  = pc + 4;
            case (opcode_e'(w[31:26]))
                OP_ADD:  regs[w[15:11]] = a + b;
                OP_SUB:  regs[w[15:11]] = a - b;
                OP_AND:  regs[w[15:11]] = a & b;
                OP_OR:   regs[w[15:11]] = a | b;
                OP_SLT:  regs[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_ADDI: regs[w[20:16]] = ea;
                OP_LW:   regs[w[20:16]] = dm[ea[9:2]];
                OP_SW: begin
                    dm[ea[9:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                OP_BEQZ: if (a == '0) pc = pc + (imm << 2);
                OP_BNEZ: if (a != '0) pc = pc + (imm << 2);
                OP_J:    pc = pc + (imm << 2);
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            regs[0] = '0;
            steps++;
        end
        run_reference = done ? exp_addr.size() : -1;
    endfunction

    // Compares each committed store in order
    always @(posedge clk) begin
        if (rst_n && mem_wr) begin
            assert (!halted) else begin
                $display("A store was seen after halted had risen");
                other_errors++;
            end
            assert (store_count < exp_addr.size()) else begin
                $display("More stores than the model expects, extra one at %h", mem_addr);
                other_errors++;
            end
            if (store_count < exp_addr.size()) begin
                assert (mem_addr == exp_addr[store_count]) else begin
                    $display("ERROR mem_addr: got %h, expected %h", mem_addr,
                             exp_addr[store_count]);
                    value_errors++;
                end
                assert (mem_wr_data == exp_data[store_count]) else begin
                    $display("ERROR mem_wr_data: got %h, expected %h", mem_wr_data,
                             exp_data[store_count]);
                    value_errors++;
                end
            end
            store_count++;
        end
    end

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        seed         = 32'he8062a93;
        prog_len     = 0;
        store_count  = 0;
        value_errors = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            dmem[i] <= dmem_init[i];
        exp_count = run_reference();
        assert (exp_count > 0) else begin
            $display("The reference model did not reach HALT within the step limit");
            other_errors++;
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (i_addr == `RESET_PC) else begin
            $display("ERROR i_addr: got %h, expected %h", i_addr, `RESET_PC);
            value_errors++;
        end
        assert (mem_wr == 1'b0 && halted == 1'b0) else begin
            $display("ERROR mem_wr/halted: got %h/%h, expected 0/0", mem_wr, halted);
            value_errors++;
        end

        wait_cycles = 0;
        while (!halted && wait_cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        assert (halted) else begin
            $display("Timed out after %0d cycles waiting for halted", HALT_TIMEOUT);
            other_errors++;
        end

        // Drain window for any late store
        repeat (20) @(posedge clk);
        assert (store_count == exp_count) else begin
            $display("ERROR store_count: got %h, expected %h", store_count, exp_count);
            value_errors++;
        end
        $display("Errors: %0d value, %0d other (stores seen %0d, expected %0d)",
                 value_errors, other_errors, store_count, exp_count);
        if (value_errors + other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: tests/cpu_assert.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             mem_wr,
    input logic             halted,
    input logic             stall,
    input logic [`XLEN-1:0] i_addr
);

    // Store strobe always driven once out of reset
    mem_wr_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(mem_wr)
    ) else $error("mem_wr is unknown after reset");

    // Sticky until reset
    halted_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else $error("halted fell without a reset");

    // Load-use stall holds fetch
    stall_holds_pc: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> $stable(i_addr)
    ) else $error("i_addr moved in the cycle after a stall");

endmodule

bind pipeline cpu_assert u_cpu_assert (
    .clk(clk), .rst_n(rst_n), .mem_wr(mem_wr), .halted(halted),
    .stall(stall), .i_addr(i_addr)
);

// File: hw/cpu_top.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] i_addr,
    input  logic [`XLEN-1:0] mem_rd_data,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wr_data,
    output logic             mem_wr,
    output logic             halted
);

    // Register file links
    logic [`XLEN-1:0]   bus_a;
    logic [`XLEN-1:0]   bus_b;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   reg_wr_data;
    logic               reg_wr;

    pipeline u_pipeline (
        .clk(clk), .rst_n(rst_n),
        .instr(instr), .i_addr(i_addr),
        .mem_rd_data(mem_rd_data), .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data), .mem_wr(mem_wr),
        .bus_a(bus_a), .bus_b(bus_b), .rs1(rs1), .rs2(rs2),
        .rd(rd), .reg_wr_data(reg_wr_data), .reg_wr(reg_wr),
        .halted(halted)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2), .bus_a(bus_a), .bus_b(bus_b),
        .rd(rd), .wr_data(reg_wr_data), .wr_en(reg_wr)
    );

endmodule

// File: hw/pipeline.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module pipeline (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`XLEN-1:0]   instr,
    output logic [`XLEN-1:0]   i_addr,
    input  logic [`XLEN-1:0]   mem_rd_data,
    output logic [`XLEN-1:0]   mem_addr,
    output logic [`XLEN-1:0]   mem_wr_data,
    output logic               mem_wr,
    input  logic [`XLEN-1:0]   bus_a,
    input  logic [`XLEN-1:0]   bus_b,
    output logic [`REG_AW-1:0] rs1,
    output logic [`REG_AW-1:0] rs2,
    output logic [`REG_AW-1:0] rd,
    output logic [`XLEN-1:0]   reg_wr_data,
    output logic               reg_wr,
    output logic               halted
);
    import cpu_pkg::*;

    localparam logic [`XLEN-1:0] WORD_BYTES = 4;

    // Fetch
    logic [`XLEN-1:0] pc;
    logic             halt_pending;
    logic             id_halt;
    logic             pc_freeze;

    // IF/ID
    logic             ifid_valid;
    logic [`XLEN-1:0] ifid_instr;
    logic [`XLEN-1:0] ifid_pc4;

    // Decode and hazard results
    alu_op_e             dec_alu_op;
    logic                dec_use_imm, dec_mem_rd, dec_mem_wr, dec_reg_wr;
    logic                dec_branch, dec_branch_nz, dec_jump, dec_halt;
    logic [`REG_AW-1:0]  dec_dest;
    logic [`XLEN-1:0]    dec_imm;
    fwd_sel_e            haz_fwd_a, haz_fwd_b;
    logic                stall, flush;

    // ID/EX
    logic                idex_valid;
    alu_op_e             idex_alu_op;
    fwd_sel_e            idex_fwd_a, idex_fwd_b;
    logic                idex_use_imm, idex_mem_rd, idex_mem_wr, idex_reg_wr;
    logic                idex_branch, idex_branch_nz, idex_jump, idex_halt;
    logic [`REG_AW-1:0]  idex_dest;
    logic [`XLEN-1:0]    idex_imm, idex_bus_a, idex_bus_b, idex_pc4;

    // EX results
    logic [`XLEN-1:0]    ex_alu_res, ex_store_data, ex_src_a, ex_target;

    // EX/MEM
    logic                exm_valid;
    logic                exm_mem_rd, exm_mem_wr, exm_reg_wr, exm_zero;
    logic                exm_branch, exm_branch_nz, exm_jump, exm_halt;
    logic [`REG_AW-1:0]  exm_dest;
    logic [`XLEN-1:0]    exm_alu_res, exm_store_data, exm_target;
    logic                take_branch;

    // MEM/WB
    logic                mwb_valid, mwb_reg_wr, mwb_mem_rd;
    logic [`REG_AW-1:0]  mwb_dest;
    logic [`XLEN-1:0]    mwb_alu_res, mwb_ld_data, wb_data;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////

    // HALT in decode stops fetch until a redirect or reset
    assign id_halt   = ifid_valid && dec_halt;
    assign pc_freeze = id_halt || halt_pending;
    assign i_addr    = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc           <= `RESET_PC;
            halt_pending <= 1'b0;
        end else begin
            if (flush)
                pc <= exm_target;
            else if (!stall && !pc_freeze)
                pc <= pc + WORD_BYTES;

            if (flush)
                halt_pending <= 1'b0;
            else if (id_halt && !stall)
                halt_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ifid_valid <= 1'b0;
        else if (flush)
            ifid_valid <= 1'b0;
        else if (!stall)
            ifid_valid <= !pc_freeze;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_instr <= instr;
            ifid_pc4   <= pc + WORD_BYTES;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign rs1 = ifid_instr[25:21];
    assign rs2 = ifid_instr[20:16];

    decode u_decode (
        .instr(ifid_instr), .alu_op(dec_alu_op), .use_imm(dec_use_imm),
        .mem_rd(dec_mem_rd), .mem_wr(dec_mem_wr), .reg_wr(dec_reg_wr),
        .branch(dec_branch), .branch_nz(dec_branch_nz), .jump(dec_jump),
        .halt(dec_halt), .dest(dec_dest), .imm(dec_imm)
    );

    hazard_unit u_hazard (
        .id_rs1(rs1), .id_rs2(rs2),
        .ex_dest(idex_dest), .ex_valid(idex_valid), .ex_mem_rd(idex_mem_rd),
        .mem_dest(exm_dest), .mem_valid(exm_valid), .mem_reg_wr(exm_reg_wr),
        .wb_dest(mwb_dest), .wb_valid(mwb_valid), .wb_reg_wr(mwb_reg_wr),
        .take_branch(take_branch),
        .fwd_a(haz_fwd_a), .fwd_b(haz_fwd_b), .stall(stall), .flush(flush)
    );

    // Stall leaves a bubble behind the held instruction
    always_ff @(posedge clk) begin
        if (!rst_n)
            idex_valid <= 1'b0;
        else
            idex_valid <= ifid_valid && !stall && !flush;
    end

    always_ff @(posedge clk) begin
        idex_alu_op    <= dec_alu_op;
        idex_use_imm   <= dec_use_imm;
        idex_mem_rd    <= dec_mem_rd;
        idex_mem_wr    <= dec_mem_wr;
        idex_reg_wr    <= dec_reg_wr;
        idex_branch    <= dec_branch;
        idex_branch_nz <= dec_branch_nz;
        idex_jump      <= dec_jump;
        idex_halt      <= dec_halt;
        idex_dest      <= dec_dest;
        idex_imm       <= dec_imm;
        idex_bus_a     <= bus_a;
        idex_bus_b     <= bus_b;
        idex_pc4       <= ifid_pc4;
        idex_fwd_a     <= haz_fwd_a;
        idex_fwd_b     <= haz_fwd_b;
    end

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    exec_unit u_exec (
        .alu_op(idex_alu_op), .use_imm(idex_use_imm),
        .fwd_a(idex_fwd_a), .fwd_b(idex_fwd_b),
        .bus_a(idex_bus_a), .bus_b(idex_bus_b), .imm(idex_imm),
        .mem_res(exm_alu_res), .wb_res(wb_data),
        .alu_res(ex_alu_res), .store_data(ex_store_data), .src_a(ex_src_a)
    );

    // Word offset relative to the next instruction
    assign ex_target = idex_pc4 + (idex_imm << 2);

    always_ff @(posedge clk) begin
        if (!rst_n)
            exm_valid <= 1'b0;
        else
            exm_valid <= idex_valid && !flush;
    end

    always_ff @(posedge clk) begin
        exm_mem_rd     <= idex_mem_rd;
        exm_mem_wr     <= idex_mem_wr;
        exm_reg_wr     <= idex_reg_wr;
        exm_branch     <= idex_branch;
        exm_branch_nz  <= idex_branch_nz;
        exm_jump       <= idex_jump;
        exm_halt       <= idex_halt;
        exm_dest       <= idex_dest;
        exm_alu_res    <= ex_alu_res;
        exm_store_data <= ex_store_data;
        exm_zero       <= (ex_src_a == '0);
        exm_target     <= ex_target;
    end

    //////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////

    assign take_branch = exm_valid &&
                         (exm_jump || (exm_branch && (exm_zero ^ exm_branch_nz)));

    assign mem_addr    = exm_alu_res;
    assign mem_wr_data = exm_store_data;
    assign mem_wr      = exm_valid && exm_mem_wr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mwb_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            mwb_valid <= exm_valid;
            if (exm_valid && exm_halt)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        mwb_reg_wr  <= exm_reg_wr;
        mwb_mem_rd  <= exm_mem_rd;
        mwb_dest    <= exm_dest;
        mwb_alu_res <= exm_alu_res;
        mwb_ld_data <= mem_rd_data;
    end

    assign wb_data     = mwb_mem_rd ? mwb_ld_data : mwb_alu_res;
    assign reg_wr_data = wb_data;
    assign rd          = mwb_dest;
    assign reg_wr      = mwb_valid && mwb_reg_wr;

endmodule

// File: hw/regfile.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   bus_a,
    output logic [`XLEN-1:0]   bus_b,
    input  logic [`REG_AW-1:0] rd,
    input  logic [`XLEN-1:0]   wr_data,
    input  logic               wr_en
);
    localparam int NREGS = 1 << `REG_AW;

    logic [`XLEN-1:0] regs [NREGS];

    // r0 reads zero, a same-cycle write is returned directly
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0)
            read_port = '0;
        else if (wr_en && (rd == addr))
            read_port = wr_data;
        else
            read_port = regs[addr];
    endfunction

    always_comb begin
        bus_a = read_port(rs1);
        bus_b = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++)
                regs[i] <= '0;
        end else if (wr_en && (rd != '0)) begin
            regs[rd] <= wr_data;
        end
    end

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module exec_unit (
    input  cpu_pkg::alu_op_e  alu_op,
    input  logic              use_imm,
    input  cpu_pkg::fwd_sel_e fwd_a,
    input  cpu_pkg::fwd_sel_e fwd_b,
    input  logic [`XLEN-1:0]  bus_a,
    input  logic [`XLEN-1:0]  bus_b,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  mem_res,
    input  logic [`XLEN-1:0]  wb_res,
    output logic [`XLEN-1:0]  alu_res,
    output logic [`XLEN-1:0]  store_data,
    output logic [`XLEN-1:0]  src_a
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] op_b;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: fwd_mux = mem_val;
            FWD_WB:  fwd_mux = wb_val;
            default: fwd_mux = reg_val;
        endcase
    endfunction

    // Forwarded operands
    assign src_a = fwd_mux(fwd_a, bus_a, mem_res, wb_res);
    assign src_b = fwd_mux(fwd_b, bus_b, mem_res, wb_res);

    // Stores carry rs2 through while the ALU forms the address
    assign store_data = src_b;
    assign op_b       = use_imm ? imm : src_b;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = src_a - op_b;
            ALU_AND: alu_res = src_a & op_b;
            ALU_OR:  alu_res = src_a | op_b;
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            default: alu_res = src_a + op_b;
        endcase
    end

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module hazard_unit (
    input  logic [`REG_AW-1:0] id_rs1,
    input  logic [`REG_AW-1:0] id_rs2,
    input  logic [`REG_AW-1:0] ex_dest,
    input  logic               ex_valid,
    input  logic               ex_mem_rd,
    input  logic [`REG_AW-1:0] mem_dest,
    input  logic               mem_valid,
    input  logic               mem_reg_wr,
    input  logic [`REG_AW-1:0] wb_dest,
    input  logic               wb_valid,
    input  logic               wb_reg_wr,
    input  logic               take_branch,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b,
    output logic               stall,
    output logic               flush
);
    import cpu_pkg::*;

    logic load_use;

    // Source for an operand of the instruction now in ID, once it sits in EX.
    // The current EX instruction will then be in EX/MEM, the current MEM
    // instruction in MEM/WB.
    function automatic fwd_sel_e pick_src(input logic [`REG_AW-1:0] rs);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex_valid && (ex_dest == rs);
        mem_hit = mem_valid && mem_reg_wr && (mem_dest == rs);
        // An instruction now in WB writes this edge and the regfile bypass returns it
        if (rs == '0)
            pick_src = FWD_REG;
        else if (ex_hit)
            pick_src = FWD_MEM;
        else if (mem_hit)
            pick_src = FWD_WB;
        else
            pick_src = FWD_REG;
    endfunction

    always_comb begin
        fwd_a = pick_src(id_rs1);
        fwd_b = pick_src(id_rs2);
    end

    // Load in EX feeding the instruction in ID
    assign load_use = ex_valid && ex_mem_rd && (ex_dest != '0) &&
                      ((ex_dest == id_rs1) || (ex_dest == id_rs2));

    // A redirect wins over the stall
    assign stall = load_use && !take_branch;
    assign flush = take_branch;

endmodule

// File: hw/decode.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module decode (
    input  logic [`XLEN-1:0]   instr,
    output cpu_pkg::alu_op_e   alu_op,
    output logic               use_imm,
    output logic               mem_rd,
    output logic               mem_wr,
    output logic               reg_wr,
    output logic               branch,
    output logic               branch_nz,
    output logic               jump,
    output logic               halt,
    output logic [`REG_AW-1:0] dest,
    output logic [`XLEN-1:0]   imm
);
    import cpu_pkg::*;

    opcode_e op;
    logic    rd_form;

    assign op  = opcode_e'(instr[31:26]);
    assign imm = {{(`XLEN-16){instr[15]}}, instr[15:0]};

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        mem_rd    = 1'b0;
        mem_wr    = 1'b0;
        reg_wr    = 1'b0;
        branch    = 1'b0;
        branch_nz = 1'b0;
        jump      = 1'b0;
        halt      = 1'b0;
        rd_form   = 1'b0;
        case (op)
            OP_ADD: begin
                reg_wr  = 1'b1;
                rd_form = 1'b1;
            end
            OP_SUB: begin
                alu_op  = ALU_SUB;
                reg_wr  = 1'b1;
                rd_form = 1'b1;
            end
            OP_AND: begin
                alu_op  = ALU_AND;
                reg_wr  = 1'b1;
                rd_form = 1'b1;
            end
            OP_OR: begin
                alu_op  = ALU_OR;
                reg_wr  = 1'b1;
                rd_form = 1'b1;
            end
            OP_SLT: begin
                alu_op  = ALU_SLT;
                reg_wr  = 1'b1;
                rd_form = 1'b1;
            end
            OP_ADDI: begin
                use_imm = 1'b1;
                reg_wr  = 1'b1;
            end
            OP_LW: begin
                use_imm = 1'b1;
                mem_rd  = 1'b1;
                reg_wr  = 1'b1;
            end
            // Address from rs1 + imm, store data from rs2
            OP_SW: begin
                use_imm = 1'b1;
                mem_wr  = 1'b1;
            end
            OP_BEQZ: branch = 1'b1;
            OP_BNEZ: begin
                branch    = 1'b1;
                branch_nz = 1'b1;
            end
            OP_J:    jump = 1'b1;
            OP_HALT: halt = 1'b1;
            default: ;
        endcase
    end

    // R-type writes rd, I-type writes the rs2 field
    // Zero when nothing is written, so hazard checks can key on dest alone
    assign dest = !reg_wr ? '0 : (rd_form ? instr[15:11] : instr[20:16]);

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

    // Primary opcode, instr[31:26]
    // Encodings not listed here decode as a no-op
    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_SLT  = 6'h05,
        OP_ADDI = 6'h08,
        OP_LW   = 6'h10,
        OP_SW   = 6'h11,
        OP_BEQZ = 6'h12,
        OP_BNEZ = 6'h13,
        OP_J    = 6'h14,
        OP_HALT = 6'h3f
    } opcode_e;

    // ALU function
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Operand source for the EX stage
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Data word and byte address width
`define XLEN 32

// Register file address width for 32 registers
`define REG_AW 5

//////////////////////////////////////////////////
// Fetch
//////////////////////////////////////////////////

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif
